/* rtl/anyDec_consts.svh */
// anyDec decoder constants
`ifndef ANYDEC_CONSTS_SVH
`define ANYDEC_CONSTS_SVH

// Data path widths
`define INST_WIDTH    40
`define VALUE_SIZE    64
`define ADDR_WIDTH    32
`define REG_WIDTH     6
`define OPCODE_WIDTH  8
`define FUNC_WIDTH    6
`define FORMAT_WIDTH  4

// Instruction field positions
`define OPC_HI     7
`define OPC_LO     0
`define RT_HI      13
`define RT_LO      8
`define RA_HI      19
`define RA_LO      14
`define RB_HI      25
`define RB_LO      20
`define FUNC_HI    31
`define FUNC_LO    26
`define IMM16_HI   35
`define IMM16_LO   20
`define DISPHI_HI  35
`define DISPHI_LO  26
`define JTGT_HI    35
`define JTGT_LO    10
`define JRT_HI     9
`define JRT_LO     8

// One queue entry is format, func, isSigned, Rt, Ra, Rb, immediate and IP
`define PREDEC_WIDTH (`FORMAT_WIDTH + `FUNC_WIDTH + 1 + 3 * `REG_WIDTH + `VALUE_SIZE + `ADDR_WIDTH)

`define QUEUE_DEPTH 4

`endif

/* rtl/anyDecPkg.sv */
// anyDec decoder types
`include "anyDec_consts.svh"

package anyDecPkg;

	typedef logic [`INST_WIDTH-1:0]   instWord_t;
	typedef logic [`ADDR_WIDTH-1:0]   address_t;
	typedef logic [`VALUE_SIZE-1:0]   value_t;
	typedef logic [`REG_WIDTH-1:0]    regNum_t;
	typedef logic [`PREDEC_WIDTH-1:0] predecEntry_t;

	// ========================================
	// Major opcodes
	// ========================================
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		BRK   = 8'h00,
		R1    = 8'h01,
		R2    = 8'h02,
		ADDI  = 8'h04,
		MULI  = 8'h06,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		XORI  = 8'h0A,
		SLTI  = 8'h0C,
		SLTUI = 8'h0D,
		NOP   = 8'h3F,
		JAL   = 8'h40,
		BEQ   = 8'h48,
		BNE   = 8'h49,
		BLT   = 8'h4A,
		BGE   = 8'h4B,
		BLTU  = 8'h4C,
		BGEU  = 8'h4D,
		LDX   = 8'h60,
		STX   = 8'h70
	} opcode_t;

	// R1 and R2 function codes share one space
	typedef enum logic [`FUNC_WIDTH-1:0] {
		ADD   = 6'h04,
		SUB   = 6'h05,
		AND   = 6'h08,
		OR    = 6'h09,
		XOR   = 6'h0A,
		SLL   = 6'h10,
		SRL   = 6'h11,
		SLLI  = 6'h12,
		SLT   = 6'h14,
		SLTU  = 6'h15,
		MUL   = 6'h18,
		MULU  = 6'h19,
		DIV   = 6'h1C,
		DIVU  = 6'h1D,
		ABS   = 6'h20,
		NOT   = 6'h21,
		CTLZ  = 6'h22,
		CTPOP = 6'h23
	} func_t;

	typedef enum logic [`FORMAT_WIDTH-1:0] {
		fmtNone, fmtR1, fmtR2, fmtAluImm, fmtBranch,
		fmtLoad, fmtStore, fmtJal, fmtIllegal
	} format_t;

endpackage

/* rtl/anyDecPredecode.sv */
// anyDec pre-decode stage
`timescale 1ns/1ns
`include "anyDec_consts.svh"

module anyDecPredecode import anyDecPkg::*; (
	input  logic         clk,
	input  logic         rstN,
	input  logic         instValid,
	output logic         instReady,
	input  instWord_t    inst,
	input  address_t     predIp,
	output logic         pushValid,
	input  logic         pushReady,
	output predecEntry_t pushEntry
);

	opcode_t opc;
	func_t   rawFunc;
	format_t fmtSel;
	func_t   funcSel;
	logic    signSel;
	regNum_t rtSel;
	value_t  immSext16;
	value_t  immZext16;
	value_t  immOnes16;
	value_t  immSplit;
	value_t  immLong;
	value_t  immSel;

	assign opc     = opcode_t'(inst[`OPC_HI:`OPC_LO]);
	assign rawFunc = func_t'(inst[`FUNC_HI:`FUNC_LO]);

	// Candidate immediates, picked below by opcode
	assign immSext16 = {{(`VALUE_SIZE-16){inst[`IMM16_HI]}}, inst[`IMM16_HI:`IMM16_LO]};
	assign immZext16 = {{(`VALUE_SIZE-16){1'b0}}, inst[`IMM16_HI:`IMM16_LO]};
	assign immOnes16 = {{(`VALUE_SIZE-16){1'b1}}, inst[`IMM16_HI:`IMM16_LO]};
	assign immSplit  = {{(`VALUE_SIZE-16){inst[`DISPHI_HI]}}, inst[`DISPHI_HI:`DISPHI_LO],
		inst[`RT_HI:`RT_LO]};
	assign immLong   = {{(`VALUE_SIZE-26){inst[`JTGT_HI]}}, inst[`JTGT_HI:`JTGT_LO]};

	// ========================================
	// Classification
	// ========================================
	// ALU immediates carry the matching R2 func so that the control stage
	// never has to look at the opcode again
	always_comb begin
		fmtSel  = fmtIllegal;
		funcSel = rawFunc;
		signSel = 1'b1;
		rtSel   = inst[`RT_HI:`RT_LO];
		immSel  = '0;
		case (opc)
			BRK, NOP: fmtSel = fmtNone;
			R1: begin
				case (rawFunc)
					ABS, NOT, CTLZ, CTPOP: fmtSel = fmtR1;
					default: ;
				endcase
			end
			R2: begin
				case (rawFunc)
					ADD, SUB, AND, OR, XOR, SLL, SRL, SLT, MUL, DIV: fmtSel = fmtR2;
					SLTU, MULU, DIVU: begin
						fmtSel  = fmtR2;
						signSel = 1'b0;
					end
					SLLI: begin
						fmtSel = fmtR2;
						immSel = {{(`VALUE_SIZE-`REG_WIDTH){1'b0}}, inst[`RB_HI:`RB_LO]};
					end
					default: ;
				endcase
			end
			ADDI: begin
				fmtSel  = fmtAluImm;
				funcSel = ADD;
				immSel  = immSext16;
			end
			ANDI: begin
				fmtSel  = fmtAluImm;
				funcSel = AND;
				immSel  = immOnes16;
			end
			ORI, XORI: begin
				fmtSel  = fmtAluImm;
				funcSel = (opc == ORI) ? OR : XOR;
				immSel  = immZext16;
			end
			SLTI: begin
				fmtSel  = fmtAluImm;
				funcSel = SLT;
				immSel  = immSext16;
			end
			SLTUI: begin
				fmtSel  = fmtAluImm;
				funcSel = SLTU;
				signSel = 1'b0;
				immSel  = immZext16;
			end
			MULI: begin
				fmtSel  = fmtAluImm;
				funcSel = MUL;
				immSel  = immSext16;
			end
			BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
				fmtSel  = fmtBranch;
				signSel = !(opc inside {BLTU, BGEU});
				immSel  = immSplit;
			end
			LDX: begin
				fmtSel = fmtLoad;
				immSel = immSext16;
			end
			STX: begin
				fmtSel = fmtStore;
				immSel = immSplit;
			end
			JAL: begin
				fmtSel = fmtJal;
				// Link register comes from the two low bits of the Rt slot
				rtSel  = {{(`REG_WIDTH-2){1'b0}}, inst[`JRT_HI:`JRT_LO]};
				immSel = immLong;
			end
			default: ;
		endcase
	end

	// Stage accepts whenever it is empty or drains this cycle
	assign instReady = !pushValid || pushReady;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pushValid <= 1'b0;
		end else if (instReady) begin
			pushValid <= instValid;
		end
	end

	always_ff @(posedge clk) begin
		if (instValid && instReady) begin
			pushEntry <= {fmtSel, funcSel, signSel, rtSel, inst[`RA_HI:`RA_LO],
				inst[`RB_HI:`RB_LO], immSel, predIp};
		end
	end

	// A stalled entry must wait in place until the queue takes it
	stallHold: assert property (@(posedge clk) disable iff (!rstN)
		pushValid && !pushReady |=> pushValid && $stable(pushEntry));

endmodule

/* rtl/anyDecQueue.sv */
// anyDec pre-decode queue
`timescale 1ns/1ns
`include "anyDec_consts.svh"

module anyDecQueue import anyDecPkg::*; #(
	parameter int DEPTH = `QUEUE_DEPTH
) (
	input  logic         clk,
	input  logic         rstN,
	input  logic         pushValid,
	output logic         pushReady,
	input  predecEntry_t pushEntry,
	output logic         popValid,
	input  logic         popReady,
	output predecEntry_t popEntry
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	predecEntry_t mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0]   count;
	logic wrEn;
	logic rdEn;

	assign pushReady = (count != DEPTH[PTR_W:0]);
	assign popValid  = (count != '0);
	assign wrEn      = pushValid && pushReady;
	assign rdEn      = popValid && popReady;

	// Head entry is read straight from storage, so a write shows one edge later
	assign popEntry = mem[rdPtr];

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrPtr] <= pushEntry;
		end
	end

	// ========================================
	// Pointers and occupancy
	// ========================================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (wrEn) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (rdEn) begin
				rdPtr <= rdPtr + 1'b1;
			end
			if (wrEn && !rdEn) begin
				count <= count + 1'b1;
			end else if (rdEn && !wrEn) begin
				count <= count - 1'b1;
			end
		end
	end

	// A write into a full queue would push the count past DEPTH
	noOverflow: assert property (@(posedge clk) disable iff (!rstN)
		wrEn && !rdEn |=> count <= DEPTH);

	// A read from an empty queue would wrap the count to its top value
	noUnderflow: assert property (@(posedge clk) disable iff (!rstN)
		rdEn && !wrEn |=> count < DEPTH);

endmodule

/* rtl/anyDecControl.sv */
// anyDec control flag stage
`timescale 1ns/1ns
`include "anyDec_consts.svh"

module anyDecControl import anyDecPkg::*; (
	input  logic         clk,
	input  logic         rstN,
	input  logic         popValid,
	output logic         popReady,
	input  predecEntry_t popEntry,
	output logic         decValid,
	input  logic         decReady,
	output regNum_t      decRt,
	output regNum_t      decRa,
	output regNum_t      decRb,
	output value_t       decImm,
	output address_t     decPip,
	output logic         decRfwr,
	output logic         decNeedRa,
	output logic         decNeedRb,
	output logic         decIsSigned,
	output logic         decMc,
	output logic         decBranch,
	output logic         decMemOp,
	output logic         decUi
);

	logic [`FORMAT_WIDTH-1:0] rawFmt;
	logic [`FUNC_WIDTH-1:0]   rawFunc;
	format_t  entFmt;
	func_t    entFunc;
	logic     entSigned;
	regNum_t  entRt;
	regNum_t  entRa;
	regNum_t  entRb;
	value_t   entImm;
	address_t entIp;
	logic     rfwr;
	logic     needRa;
	logic     needRb;
	logic     mc;
	logic     memOp;
	logic     ui;
	logic     mulDiv;

	assign {rawFmt, rawFunc, entSigned, entRt, entRa, entRb, entImm, entIp} = popEntry;
	assign entFmt  = format_t'(rawFmt);
	assign entFunc = func_t'(rawFunc);

	// ========================================
	// Flag derivation from format and func
	// ========================================
	assign ui     = (entFmt == fmtIllegal);
	assign rfwr   = entFmt inside {fmtR1, fmtR2, fmtAluImm, fmtLoad, fmtJal};
	assign needRa = !(entFmt inside {fmtNone, fmtJal, fmtIllegal});
	assign needRb = entFmt inside {fmtR2, fmtBranch, fmtStore};
	assign memOp  = entFmt inside {fmtLoad, fmtStore};

	// MULI arrives tagged as MUL, so one check covers both forms
	assign mulDiv = entFmt inside {fmtR2, fmtAluImm} && entFunc inside {MUL, MULU, DIV, DIVU};
	assign mc     = mulDiv || entFmt inside {fmtBranch, fmtLoad, fmtStore, fmtJal};

	assign popReady = !decValid || decReady;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decValid <= 1'b0;
		end else if (popReady) begin
			decValid <= popValid;
		end
	end

	always_ff @(posedge clk) begin
		if (popValid && popReady) begin
			// No target register unless the instruction writes one
			decRt       <= rfwr ? entRt : '0;
			decRa       <= entRa;
			decRb       <= entRb;
			decImm      <= entImm;
			decPip      <= entIp;
			decRfwr     <= rfwr;
			decNeedRa   <= needRa;
			decNeedRb   <= needRb;
			decIsSigned <= entSigned && !ui;
			decMc       <= mc;
			decBranch   <= (entFmt == fmtBranch);
			decMemOp    <= memOp;
			decUi       <= ui;
		end
	end

	// An unimplemented encoding must never reach execution as a real operation
	uiExclusive: assert property (@(posedge clk) disable iff (!rstN)
		decValid && decUi |-> !(decRfwr || decMc || decMemOp));

endmodule

/* rtl/anyDecTop.sv */
// anyDec decode stage top
`timescale 1ns/1ns
`include "anyDec_consts.svh"

module anyDecTop import anyDecPkg::*; (
	input  logic      clk,
	input  logic      rstN,
	input  logic      instValid,
	output logic      instReady,
	input  instWord_t inst,
	input  address_t  predIp,
	output logic      decValid,
	input  logic      decReady,
	output regNum_t   decRt,
	output regNum_t   decRa,
	output regNum_t   decRb,
	output value_t    decImm,
	output address_t  decPip,
	output logic      decRfwr,
	output logic      decNeedRa,
	output logic      decNeedRb,
	output logic      decIsSigned,
	output logic      decMc,
	output logic      decBranch,
	output logic      decMemOp,
	output logic      decUi
);

	logic         pushValid;
	logic         pushReady;
	predecEntry_t pushEntry;
	logic         popValid;
	logic         popReady;
	predecEntry_t popEntry;

	// Pre-decode, queue, then flag generation
	anyDecPredecode uPredecode (
		.clk(clk), .rstN(rstN),
		.instValid(instValid), .instReady(instReady), .inst(inst), .predIp(predIp),
		.pushValid(pushValid), .pushReady(pushReady), .pushEntry(pushEntry)
	);

	anyDecQueue #(.DEPTH(`QUEUE_DEPTH)) uQueue (
		.clk(clk), .rstN(rstN),
		.pushValid(pushValid), .pushReady(pushReady), .pushEntry(pushEntry),
		.popValid(popValid), .popReady(popReady), .popEntry(popEntry)
	);

	anyDecControl uControl (
		.clk(clk), .rstN(rstN),
		.popValid(popValid), .popReady(popReady), .popEntry(popEntry),
		.decValid(decValid), .decReady(decReady),
		.decRt(decRt), .decRa(decRa), .decRb(decRb), .decImm(decImm), .decPip(decPip),
		.decRfwr(decRfwr), .decNeedRa(decNeedRa), .decNeedRb(decNeedRb),
		.decIsSigned(decIsSigned), .decMc(decMc), .decBranch(decBranch),
		.decMemOp(decMemOp), .decUi(decUi)
	);

endmodule

/* verif/anyDecModel.svh */
// anyDec reference model
`ifndef ANYDEC_MODEL_SVH
`define ANYDEC_MODEL_SVH

typedef struct packed {
	regNum_t  rt;
	regNum_t  ra;
	regNum_t  rb;
	value_t   imm;
	address_t pip;
	logic     rfwr;
	logic     needRa;
	logic     needRb;
	logic     isSigned;
	logic     mc;
	logic     branch;
	logic     memOp;
	logic     ui;
} expBundle_t;

// Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic instWord_t withOpcode(input instWord_t base, input logic [7:0] opc);
	return {base[`INST_WIDTH-1:`OPC_HI+1], opc};
endfunction

function automatic instWord_t withFunc(input instWord_t base, input logic [7:0] opc,
	input logic [5:0] fn);
	instWord_t w;
	w = withOpcode(base, opc);
	w[`FUNC_HI:`FUNC_LO] = fn;
	return w;
endfunction

// ========================================
// Expected decode of one instruction
// ========================================
function automatic expBundle_t expectDecode(input instWord_t w, input address_t ip);
	logic [7:0] opc;
	logic [5:0] fn;
	logic       r1;
	logic       r2;
	logic       aluImm;
	logic       br;
	logic       ld;
	logic       st;
	logic       jal;
	logic       bare;
	expBundle_t e;
	opc    = w[7:0];
	fn     = w[31:26];
	r1     = (opc == R1) && (fn inside {ABS, NOT, CTLZ, CTPOP});
	r2     = (opc == R2) && (fn inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SLLI, SLT, SLTU,
		MUL, MULU, DIV, DIVU});
	aluImm = opc inside {ADDI, ANDI, ORI, XORI, SLTI, SLTUI, MULI};
	br     = opc inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
	ld     = (opc == LDX);
	st     = (opc == STX);
	jal    = (opc == JAL);
	bare   = opc inside {BRK, NOP};
	e      = '0;
	e.ra   = w[19:14];
	e.rb   = w[25:20];
	e.pip  = ip;
	e.ui   = !(r1 || r2 || aluImm || br || ld || st || jal || bare);
	if (!e.ui) begin
		e.rfwr     = r1 || r2 || aluImm || ld || jal;
		e.needRa   = !(bare || jal);
		e.needRb   = r2 || br || st;
		e.mc       = (r2 && (fn inside {MUL, MULU, DIV, DIVU})) || (opc == MULI) || br || ld
			|| st || jal;
		e.branch   = br;
		e.memOp    = ld || st;
		e.isSigned = !((r2 && (fn inside {SLTU, MULU, DIVU})) || (opc inside {SLTUI, BLTU, BGEU}));
	end
	if (e.rfwr) begin
		e.rt = jal ? {4'b0, w[9:8]} : w[13:8];
	end
	if (opc inside {ADDI, SLTI, MULI, LDX}) begin
		e.imm = {{48{w[35]}}, w[35:20]};
	end else if (opc == ANDI) begin
		e.imm = {{48{1'b1}}, w[35:20]};
	end else if (opc inside {ORI, XORI, SLTUI}) begin
		e.imm = {48'b0, w[35:20]};
	end else if (r2 && fn == SLLI) begin
		e.imm = {58'b0, w[25:20]};
	end else if (br || st) begin
		e.imm = {{48{w[35]}}, w[35:26], w[13:8]};
	end else if (jal) begin
		e.imm = {{38{w[35]}}, w[35:10]};
	end
	return e;
endfunction

`endif

/* verif/anyDecTb.sv */
// anyDec decode stage testbench
`timescale 1ns/1ns
`include "anyDec_consts.svh"

module anyDecTb import anyDecPkg::*; ();

	`include "anyDecModel.svh"

	localparam logic [31:0] SEED = 32'h5a0a_aca5;
	localparam int CLK_PERIOD  = 40;
	localparam int UI_COUNT    = 12;
	localparam int STALL_COUNT = 60;
	// Functions, immediates, flow ops, unimplemented encodings and the stall run
	localparam int TEST_COUNT  = 2 * 18 + 2 * 9 + 2 * 8 + 2 * UI_COUNT + STALL_COUNT;

	logic clk;
	logic rstN;
	logic instValid;
	logic instReady;
	instWord_t inst;
	address_t predIp;
	logic decValid;
	logic decReady;
	regNum_t decRt;
	regNum_t decRa;
	regNum_t decRb;
	value_t decImm;
	address_t decPip;
	logic decRfwr;
	logic decNeedRa;
	logic decNeedRb;
	logic decIsSigned;
	logic decMc;
	logic decBranch;
	logic decMemOp;
	logic decUi;

	logic [31:0] stimLfsr;
	logic [31:0] readyLfsr;
	logic stallMode;
	logic sawStall;
	logic headValid;
	int runLeft;
	int inCount;
	int outCount;
	expBundle_t expQ[$];
	expBundle_t expHead;

	func_t r1Funcs[4] = '{ABS, NOT, CTLZ, CTPOP};
	func_t r2Funcs[14] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SLLI, SLT, SLTU, MUL, MULU, DIV,
		DIVU};
	opcode_t immOps[7] = '{ADDI, ANDI, ORI, XORI, SLTI, SLTUI, MULI};
	opcode_t flowOps[8] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU, STX, JAL};

	anyDecTop DUT (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic failRun(input string line);
		$display("%s", line);
		$display("Some tests failed");
		$fatal(1, "decoder test aborted");
	endtask

	task automatic fieldMismatch(input string name);
		failRun($sformatf("mismatch at %0t ns: %s differs from the expected value", $time, name));
	endtask

	// Two generators so that stimulus and back-pressure do not disturb each other
	function automatic logic [63:0] randBits(input logic forReady, input int n);
		logic [63:0] r;
		logic [31:0] s;
		int k;
		r = '0;
		s = forReady ? readyLfsr : stimLfsr;
		for (k = 0; k < n; k++) begin
			s = lfsrStep(s);
			r = {r[62:0], s[0]};
		end
		if (forReady) begin
			readyLfsr = s;
		end else begin
			stimLfsr = s;
		end
		return r;
	endfunction

	task automatic sendInst(input instWord_t w);
		@(negedge clk);
		instValid = 1'b1;
		inst      = w;
		predIp    = address_t'(randBits(1'b0, `ADDR_WIDTH));
		@(posedge clk);
		while (!instReady) begin
			@(posedge clk);
		end
	endtask

	// ========================================
	// Scoreboard and checks
	// ========================================
	always @(posedge clk) begin
		if (decValid && decReady) begin
			outCount++;
			if (expQ.size() > 0) begin
				void'(expQ.pop_front());
			end
		end
		if (instValid && instReady) begin
			expQ.push_back(expectDecode(inst, predIp));
			inCount++;
		end
		if (instValid && !instReady) begin
			sawStall = 1'b1;
		end
		headValid = (expQ.size() > 0);
		if (headValid) begin
			expHead = expQ[0];
		end
	end

	property fieldOk(actual, expected);
		@(posedge clk) disable iff (!rstN) decValid && decReady |-> actual == expected;
	endproperty

	chkPending: assert property (fieldOk(headValid, 1'b1))
		else failRun("decoder produced an output with no instruction pending");
	chkRt: assert property (fieldOk(decRt, expHead.rt)) else fieldMismatch("decRt");
	chkRa: assert property (fieldOk(decRa, expHead.ra)) else fieldMismatch("decRa");
	chkRb: assert property (fieldOk(decRb, expHead.rb)) else fieldMismatch("decRb");
	chkImm: assert property (fieldOk(decImm, expHead.imm)) else fieldMismatch("decImm");
	chkPip: assert property (fieldOk(decPip, expHead.pip)) else fieldMismatch("decPip");
	chkRfwr: assert property (fieldOk(decRfwr, expHead.rfwr)) else fieldMismatch("decRfwr");
	chkNeedRa: assert property (fieldOk(decNeedRa, expHead.needRa)) else fieldMismatch("decNeedRa");
	chkNeedRb: assert property (fieldOk(decNeedRb, expHead.needRb)) else fieldMismatch("decNeedRb");
	chkSigned: assert property (fieldOk(decIsSigned, expHead.isSigned))
		else fieldMismatch("decIsSigned");
	chkMc: assert property (fieldOk(decMc, expHead.mc)) else fieldMismatch("decMc");
	chkBranch: assert property (fieldOk(decBranch, expHead.branch)) else fieldMismatch("decBranch");
	chkMemOp: assert property (fieldOk(decMemOp, expHead.memOp)) else fieldMismatch("decMemOp");
	chkUi: assert property (fieldOk(decUi, expHead.ui)) else fieldMismatch("decUi");

	// Back-pressure alternates short ready runs with long stalls
	always @(negedge clk) begin
		if (!stallMode) begin
			decReady = 1'b1;
			runLeft  = 0;
		end else if (runLeft == 0) begin
			decReady = !decReady;
			runLeft  = decReady ? 1 + int'(randBits(1'b1, 3)) : 4 + int'(randBits(1'b1, 4));
		end else begin
			runLeft--;
		end
	end

	initial begin
		#(TEST_COUNT * 10 * CLK_PERIOD);
		failRun("decoder stopped producing output before all instructions came out");
	end

	// ========================================
	// Stimulus
	// ========================================
	initial begin
		instWord_t w;
		expBundle_t probe;
		opcode_t opc;
		int k;
		int s;
		clk       = 1'b0;
		rstN      = 1'b0;
		instValid = 1'b0;
		inst      = '0;
		predIp    = '0;
		decReady  = 1'b1;
		stallMode = 1'b0;
		sawStall  = 1'b0;
		headValid = 1'b0;
		expHead   = '0;
		runLeft   = 0;
		inCount   = 0;
		outCount  = 0;
		stimLfsr  = SEED;
		readyLfsr = SEED;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		resetState: assert (!decValid && instReady)
			else failRun($sformatf("mismatch at %0t ns: decValid %b instReady %b after reset",
				$time, decValid, instReady));

		for (s = 0; s < 2; s++) begin
			for (k = 0; k < 4; k++) begin
				sendInst(withFunc(instWord_t'(randBits(1'b0, `INST_WIDTH)), R1, r1Funcs[k]));
			end
			for (k = 0; k < 14; k++) begin
				sendInst(withFunc(instWord_t'(randBits(1'b0, `INST_WIDTH)), R2, r2Funcs[k]));
			end
		end

		// Immediate forms with the imm16 sign bit forced both ways
		for (s = 0; s < 2; s++) begin
			for (k = 0; k < 9; k++) begin
				w = instWord_t'(randBits(1'b0, `INST_WIDTH));
				w[`IMM16_HI] = s[0];
				if (k < 7) begin
					w = withOpcode(w, immOps[k]);
				end else if (k == 7) begin
					w = withOpcode(w, LDX);
				end else begin
					w = withFunc(w, R2, SLLI);
				end
				sendInst(w);
			end
			for (k = 0; k < 8; k++) begin
				w = instWord_t'(randBits(1'b0, `INST_WIDTH));
				w[`DISPHI_HI] = s[0];
				sendInst(withOpcode(w, flowOps[k]));
			end
		end

		for (k = 0; k < UI_COUNT; k++) begin
			w = instWord_t'(randBits(1'b0, `INST_WIDTH));
			do begin
				w = withOpcode(w, 8'(randBits(1'b0, 8)));
				probe = expectDecode(w, '0);
			end while (!probe.ui);
			sendInst(w);
			opc = randBits(1'b0, 1) ? R2 : R1;
			do begin
				w = withFunc(w, opc, 6'(randBits(1'b0, 6)));
				probe = expectDecode(w, '0);
			end while (!probe.ui);
			sendInst(w);
		end

		stallMode = 1'b1;
		for (k = 0; k < STALL_COUNT; k++) begin
			w = instWord_t'(randBits(1'b0, `INST_WIDTH));
			if (randBits(1'b0, 1)) begin
				opc = immOps[int'(randBits(1'b0, 3)) % 7];
			end else begin
				opc = flowOps[int'(randBits(1'b0, 3))];
			end
			sendInst(withOpcode(w, opc));
		end
		@(negedge clk);
		instValid = 1'b0;
		wait (outCount == inCount);
		@(negedge clk);
		stallMode = 1'b0;

		if (sawStall && outCount == TEST_COUNT) begin
			$display("All tests passed");
			$finish;
		end else begin
			failRun("instReady never dropped under back-pressure or an instruction went missing");
		end
	end

endmodule

/* anyDec.f */
+incdir+rtl
+incdir+verif
rtl/anyDecPkg.sv
rtl/anyDecPredecode.sv
rtl/anyDecQueue.sv
rtl/anyDecControl.sv
rtl/anyDecTop.sv
verif/anyDecTb.sv

/* Bender.yml */
package:
  name: anyDec

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/anyDecPkg.sv
      - rtl/anyDecPredecode.sv
      - rtl/anyDecQueue.sv
      - rtl/anyDecControl.sv
      - rtl/anyDecTop.sv
  - target: test
    include_dirs:
      - rtl
      - verif
    files:
      - verif/anyDecTb.sv
